// ==== Makefile ====
# Verilator build and run of the RVFI checker testbench

VERILATOR ?= verilator
TOP       ?= tb_rvfi_check
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= No errors

SRCS := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass message appears as a line of its own
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/rvfi_cause_check.sv ====
// Checks debug, exception and interrupt causes of each retired record against the trap rules
`timescale 1ns/1ps

module rvfi_cause_check
  import rvfi_check_pkg::*;
#(
  parameter logic SMCLIC          = 1'b0,
  parameter int   SMCLIC_ID_WIDTH = 8
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rvfi_rec_t rvfi,
  output viol_t     cause_viol
);

  logic        was_dbg_mode;
  logic [2:0]  dcsr_cause;
  logic [10:0] mcause_exccode;
  logic        irq_legal;
  logic        intr_missing;
  logic        dbg_bad;
  logic        exc_bad;
  logic        irq_bad;
  logic        missing;
  viol_t       viol_d;

  // Debug mode as seen on the previous retirement
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode <= 1'b0;
    end else if (rvfi.valid) begin
      was_dbg_mode <= rvfi.dbg_mode;
    end
  end

  assign dcsr_cause = rvfi.csr_dcsr_rdata[DCSR_CAUSE_LSB +: 3];

  // Debug entry only, retirements already inside debug mode are not checked
  assign dbg_bad = rvfi.valid && (|rvfi.dbg) && !was_dbg_mode
                   && (rvfi.dbg != dcsr_cause);

  // Exception code as written to mcause
  assign mcause_exccode = rvfi.csr_mcause_wdata[10:0] & rvfi.csr_mcause_wmask[10:0];

  assign exc_bad = rvfi.valid && rvfi.trap.exception && !rvfi.dbg_mode
                   && ({5'b0, rvfi.trap.exception_cause} != mcause_exccode);

  // Legal interrupt causes depend on the interrupt controller
  if (!SMCLIC) begin : gen_clint
    assign irq_legal = rvfi.intr.cause inside {11'd3, 11'd7, 11'd11,
                                               [11'd16 : 11'd31],
                                               [11'd1024 : 11'd1027]};

    // CLINT traps reported on rvfi_intr always carry a cause
    assign intr_missing = (rvfi.intr.interrupt || rvfi.intr.exception)
                          && (rvfi.intr.cause == 11'd0);
  end else begin : gen_clic
    localparam logic [31:0] MAX_CLIC_ID = 32'(2 ** SMCLIC_ID_WIDTH - 1);

    assign irq_legal = (32'(rvfi.intr.cause) <= MAX_CLIC_ID)
                       || (rvfi.intr.cause inside {[11'd1024 : 11'd1027]});

    // CLIC interrupt 0 is a legal ID, so a zero cause says nothing
    assign intr_missing = 1'b0;
  end

  assign irq_bad = rvfi.valid && rvfi.intr.interrupt && !irq_legal;

  assign missing = rvfi.valid && (
                     (rvfi.trap.exception && (rvfi.trap.exception_cause == 6'd0))
                     || (rvfi.trap.debug && (rvfi.trap.debug_cause == 3'd0))
                     || intr_missing);

  always_comb begin
    viol_d               = '0;
    viol_d.dbg_cause     = dbg_bad;
    viol_d.exc_cause     = exc_bad;
    viol_d.irq_illegal   = irq_bad;
    viol_d.cause_missing = missing;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cause_viol <= '0;
    end else begin
      cause_viol <= viol_d;
    end
  end

endmodule

// ==== hdl/rvfi_check_pkg.sv ====
// Shared types, violation classes and register map, imported by every module of the RVFI checker
package rvfi_check_pkg;

  // Trap information as reported on the RVFI trace
  typedef struct packed {
    logic       exception;
    logic [5:0] exception_cause;
    logic       debug;
    logic [2:0] debug_cause;
    logic [2:0] reserved;
  } rvfi_trap_t;

  // Interrupt information as reported on the RVFI trace
  typedef struct packed {
    logic        interrupt;
    logic        exception;
    logic [10:0] cause;
  } rvfi_intr_t;

  // One retirement record, sampled on every cycle with valid high
  typedef struct packed {
    logic       valid;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_rdata;
    logic [31:0] rs2_rdata;
    logic [2:0]  dbg;
    logic [31:0] csr_dcsr_rdata;
    rvfi_trap_t  trap;
    rvfi_intr_t  intr;
    logic [31:0] csr_mcause_wdata;
    logic [31:0] csr_mcause_wmask;
    logic        dbg_mode;
  } rvfi_rec_t;

  // Violation classes, listed MSB first so that class index i sits at bit i
  typedef struct packed {
    logic cause_missing;
    logic irq_illegal;
    logic exc_cause;
    logic dbg_cause;
    logic rs_reset;
  } viol_t;

  localparam int N_VIOL = 5;

  // dcsr.cause occupies bits 8:6
  localparam int DCSR_CAUSE_LSB = 6;

  // First-failure word layout
  localparam int FF_CLS_W     = 3;
  localparam int FF_VALID_BIT = 7;
  localparam int FF_IDX_LSB   = 8;

  // Register word addresses
  localparam logic [3:0] REG_STATUS   = 4'd0;
  localparam logic [3:0] REG_CLEAR    = 4'd1;
  localparam logic [3:0] REG_CNT_BASE = 4'd2;
  localparam logic [3:0] REG_RETIRED  = 4'd7;
  localparam logic [3:0] REG_FIRST    = 4'd8;

  // Wishbone classic request, master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // Wishbone classic response, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// ==== hdl/rvfi_check_top.sv ====
// Top level of the RVFI trace checker, fed by the trace and read over Wishbone
`timescale 1ns/1ps

module rvfi_check_top
  import rvfi_check_pkg::*;
#(
  parameter logic SMCLIC          = 1'b0,
  parameter int   SMCLIC_ID_WIDTH = 8,
  parameter int   CNT_WIDTH       = 16
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rvfi_rec_t rvfi,
  input  wb_req_t   wb_req,
  output wb_rsp_t   wb_rsp
);

  logic                             rs_viol;
  logic                             viol_valid;
  viol_t                            cause_viol;
  viol_t                            viol;
  viol_t                            status;
  logic [N_VIOL-1:0][CNT_WIDTH-1:0] counts;
  logic [31:0]                      retired;
  logic [31:0]                      first_fail;
  logic                             clear;

  rvfi_reset_check u_reset_check (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rvfi      (rvfi),
    .rs_viol   (rs_viol),
    .chk_valid (viol_valid)
  );

  rvfi_cause_check #(
    .SMCLIC          (SMCLIC),
    .SMCLIC_ID_WIDTH (SMCLIC_ID_WIDTH)
  ) u_cause_check (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rvfi       (rvfi),
    .cause_viol (cause_viol)
  );

  // Both checkers share the same one-cycle latency
  assign viol = '{rs_reset:      rs_viol,
                  dbg_cause:     cause_viol.dbg_cause,
                  exc_cause:     cause_viol.exc_cause,
                  irq_illegal:   cause_viol.irq_illegal,
                  cause_missing: cause_viol.cause_missing};

  rvfi_err_log #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_err_log (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .viol       (viol),
    .viol_valid (viol_valid),
    .clear      (clear),
    .status     (status),
    .counts     (counts),
    .retired    (retired),
    .first_fail (first_fail)
  );

  rvfi_wb_regs #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_wb_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .status     (status),
    .counts     (counts),
    .retired    (retired),
    .first_fail (first_fail),
    .clear      (clear)
  );

endmodule

// ==== hdl/rvfi_err_log.sv ====
// Collects checker results into sticky flags, saturating counters and a first-failure record
`timescale 1ns/1ps

module rvfi_err_log
  import rvfi_check_pkg::*;
#(
  parameter int CNT_WIDTH = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  viol_t                            viol,
  input  logic                             viol_valid,
  input  logic                             clear,
  output viol_t                            status,
  output logic [N_VIOL-1:0][CNT_WIDTH-1:0] counts,
  output logic [31:0]                      retired,
  output logic [31:0]                      first_fail
);

  logic [N_VIOL-1:0]   hit;
  logic [FF_CLS_W-1:0] first_cls;
  logic [31:0]         ff_capture;

  assign hit = {N_VIOL{viol_valid}} & viol;

  // Lowest flagged class wins when several fire together
  always_comb begin
    first_cls = '0;
    for (int i = N_VIOL - 1; i >= 0; i--) begin
      if (hit[i]) begin
        first_cls = FF_CLS_W'(i);
      end
    end
  end

  // Retirement index is zero based, taken before this record is counted
  always_comb begin
    ff_capture                   = '0;
    ff_capture[FF_CLS_W-1:0]     = first_cls;
    ff_capture[FF_VALID_BIT]     = 1'b1;
    ff_capture[31:FF_IDX_LSB]    = retired[31-FF_IDX_LSB:0];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status     <= '0;
      counts     <= '0;
      retired    <= '0;
      first_fail <= '0;
    end else if (clear) begin
      // Clear has priority over a violation in the same cycle
      status     <= '0;
      counts     <= '0;
      retired    <= '0;
      first_fail <= '0;
    end else begin
      status <= status | hit;
      for (int i = 0; i < N_VIOL; i++) begin
        if (hit[i] && (counts[i] != '1)) begin
          counts[i] <= counts[i] + 1'b1;
        end
      end
      if (viol_valid) begin
        retired <= retired + 32'd1;
      end
      if ((|hit) && !first_fail[FF_VALID_BIT]) begin
        first_fail <= ff_capture;
      end
    end
  end

endmodule

// ==== hdl/rvfi_reset_check.sv ====
// Flags non-zero source register data on the first retirement after reset
`timescale 1ns/1ps

module rvfi_reset_check
  import rvfi_check_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rvfi_rec_t rvfi,
  output logic      rs_viol,
  output logic      chk_valid
);

  logic first_pending;
  logic rs1_bad;
  logic rs2_bad;

  // x0 always reads zero, so only non-zero addresses are of interest
  assign rs1_bad = (|rvfi.rs1_addr) && (|rvfi.rs1_rdata);
  assign rs2_bad = (|rvfi.rs2_addr) && (|rvfi.rs2_rdata);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_pending <= 1'b1;
      rs_viol       <= 1'b0;
      chk_valid     <= 1'b0;
    end else begin
      chk_valid <= rvfi.valid;
      rs_viol   <= rvfi.valid && first_pending && (rs1_bad || rs2_bad);
      // Only the first record after reset is checked
      if (rvfi.valid) begin
        first_pending <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/rvfi_wb_regs.sv ====
// Wishbone classic slave exposing the violation log and accepting clear commands
`timescale 1ns/1ps

module rvfi_wb_regs
  import rvfi_check_pkg::*;
#(
  parameter int CNT_WIDTH = 16
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  wb_req_t                          wb_req,
  output wb_rsp_t                          wb_rsp,
  input  viol_t                            status,
  input  logic [N_VIOL-1:0][CNT_WIDTH-1:0] counts,
  input  logic [31:0]                      retired,
  input  logic [31:0]                      first_fail,
  output logic                             clear
);

  logic        ack_q;
  logic [3:0]  cnt_idx;
  logic [31:0] rdata;

  // One ack per transfer, the master holds the request until it sees it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_req.cyc && wb_req.stb && !ack_q;
    end
  end

  // Addresses below the counter block wrap to large indices and miss
  assign cnt_idx = wb_req.adr - REG_CNT_BASE;

  always_comb begin
    rdata = '0;
    case (wb_req.adr)
      REG_STATUS: begin
        rdata = 32'(status);
      end
      REG_RETIRED: begin
        rdata = retired;
      end
      REG_FIRST: begin
        rdata = first_fail;
      end
      default: begin
        if (cnt_idx < 4'(N_VIOL)) begin
          rdata = 32'(counts[cnt_idx[2:0]]);
        end
      end
    endcase
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = ack_q ? rdata : '0;

  // Bit 0 of the write data requests the clear, applied in the ack cycle
  assign clear = ack_q && wb_req.we && (wb_req.adr == REG_CLEAR) && wb_req.dat[0];

endmodule

// ==== tb.f ====
+incdir+testbench
hdl/rvfi_check_pkg.sv
hdl/rvfi_reset_check.sv
hdl/rvfi_cause_check.sv
hdl/rvfi_err_log.sv
hdl/rvfi_wb_regs.sv
hdl/rvfi_check_top.sv
testbench/tb_rvfi_check.sv

// ==== testbench/tb_rvfi_tasks.svh ====
// Trace, Wishbone, compare and random helpers, included inside the testbench top module

  // One retirement record with no trap and no debug activity
  function automatic rvfi_rec_t blank_record();
    rvfi_rec_t r;
    r       = '0;
    r.valid = 1'b1;
    return r;
  endfunction

  // dcsr with the given cause in bits 8:6
  function automatic logic [31:0] dcsr_with_cause(input logic [2:0] cause);
    return {23'b0, cause, 6'b0};
  endfunction

  // CLINT legal set is 3, 7, 11, 16..31 and 1024..1027
  function automatic logic clint_legal(input logic [10:0] cause);
    return (cause == 11'd3) || (cause == 11'd7) || (cause == 11'd11)
           || (cause >= 11'd16 && cause <= 11'd31)
           || (cause >= 11'd1024 && cause <= 11'd1027);
  endfunction

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s, got 0x%08h, expected 0x%08h", $time, msg, got, exp);
    end
  endtask

  // Record is held for one clock, then the trace goes idle
  task automatic send_rec(input rvfi_rec_t r);
    @(negedge clk_i);
    rvfi = r;
    @(negedge clk_i);
    rvfi = '0;
  endtask

  // Request stays up through the ack cycle, then is released
  task automatic wb_access(input logic we, input logic [3:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    rdata = '0;
    @(negedge clk_i);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = addr;
    wb_req.dat = wdata;
    cycles = 0;
    while (!wb_rsp.ack && cycles < ACK_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (wb_rsp.ack) begin
      rdata = wb_rsp.dat;
    end else begin
      errors++;
      $display("Timeout: no Wishbone ack at time %0t for register %0d", $time, addr);
    end
    @(negedge clk_i);
    wb_req = '0;
  endtask

  task automatic wb_read(input logic [3:0] addr, output logic [31:0] data);
    wb_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic wb_write(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, addr, data, unused);
  endtask

// ==== testbench/tb_rvfi_check.sv ====
// Testbench top for the RVFI trace checker, compiled as the simulation top with the file list
`timescale 1ns/1ps

module tb_rvfi_check
  import rvfi_check_pkg::*;
();

  localparam int ACK_TIMEOUT = 20;

  // One bit per violation class, in class index order
  localparam logic [4:0] F_RS   = 5'b00001;
  localparam logic [4:0] F_DBG  = 5'b00010;
  localparam logic [4:0] F_EXC  = 5'b00100;
  localparam logic [4:0] F_IRQ  = 5'b01000;
  localparam logic [4:0] F_MISS = 5'b10000;

  logic      clk_i;
  logic      rst_ni;
  rvfi_rec_t rvfi;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;

  int          errors;
  logic [31:0] rand_state;

  // Expected log contents
  int          exp_cnt [N_VIOL];
  int          exp_retired;
  logic [31:0] exp_status;
  logic [31:0] exp_first;

  rvfi_check_top #(
    .SMCLIC          (1'b0),
    .SMCLIC_ID_WIDTH (8),
    .CNT_WIDTH       (16)
  ) u_dut (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rvfi   (rvfi),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #20 clk_i = ~clk_i;

  `include "tb_rvfi_tasks.svh"

  task automatic clear_model();
    for (int i = 0; i < N_VIOL; i++) begin
      exp_cnt[i] = 0;
    end
    exp_retired = 0;
    exp_status  = '0;
    exp_first   = '0;
  endtask

  task automatic do_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    rvfi   = '0;
    wb_req = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    clear_model();
  endtask

  // Update the expected log for one retired record
  task automatic note_record(input logic [4:0] flags);
    int cls;
    cls = -1;
    for (int i = 0; i < N_VIOL; i++) begin
      if (flags[i]) begin
        exp_cnt[i]++;
        exp_status[i] = 1'b1;
        // The lowest flagged class is the one recorded as first failure
        if (cls < 0) begin
          cls = i;
        end
      end
    end
    if (cls >= 0 && !exp_first[7]) begin
      exp_first = {24'(exp_retired), 1'b1, 4'b0, 3'(cls)};
    end
    exp_retired++;
  endtask

  task automatic push_rec(input rvfi_rec_t r, input logic [4:0] flags);
    send_rec(r);
    note_record(flags);
  endtask

  // Read every mapped register and compare with the model
  task automatic check_regs(input string tag);
    logic [31:0] data;
    wb_read(REG_STATUS, data);
    check_equal(data, exp_status, $sformatf("%s status", tag));
    for (int i = 0; i < N_VIOL; i++) begin
      wb_read(REG_CNT_BASE + 4'(i), data);
      check_equal(data, 32'(exp_cnt[i]), $sformatf("%s counter %0d", tag, i));
    end
    wb_read(REG_RETIRED, data);
    check_equal(data, 32'(exp_retired), $sformatf("%s retired", tag));
    wb_read(REG_FIRST, data);
    check_equal(data, exp_first, $sformatf("%s first failure", tag));
  endtask

  task automatic test_reset_rule();
    rvfi_rec_t   r;
    logic [31:0] data;
    r = blank_record();
    r.rs1_addr = 5'd5;
    push_rec(r, 5'b0);
    check_regs("reset clean");
    wb_write(REG_CLEAR, 32'hFFFF_FFFF);
    clear_model();
    // Only the first record after reset is subject to the rule
    r = blank_record();
    r.rs1_addr  = 5'd3;
    r.rs1_rdata = 32'hDEAD_BEEF;
    r.rs2_addr  = 5'd4;
    r.rs2_rdata = xorshift32();
    push_rec(r, 5'b0);
    check_regs("after clear");
    do_reset();
    r = blank_record();
    r.rs2_addr  = 5'd7;
    r.rs2_rdata = xorshift32() | 32'h1;
    push_rec(r, F_RS);
    wb_read(REG_STATUS, data);
    check_equal(data, 32'h1, "rs_reset status after reset");
    wb_read(REG_CNT_BASE, data);
    check_equal(data, 32'd1, "rs_reset counter");
    check_regs("reset violation");
  endtask

  task automatic test_debug_cause();
    rvfi_rec_t r;
    // Matching debug entry
    r = blank_record();
    r.dbg               = 3'd3;
    r.csr_dcsr_rdata    = dcsr_with_cause(3'd3);
    r.trap.debug        = 1'b1;
    r.trap.debug_cause  = 3'd3;
    r.dbg_mode          = 1'b1;
    push_rec(r, 5'b0);
    push_rec(blank_record(), 5'b0);
    // Mismatching entry from outside debug mode
    r.dbg              = 3'd1;
    r.csr_dcsr_rdata   = dcsr_with_cause(3'd2);
    r.trap.debug_cause = 3'd1;
    push_rec(r, F_DBG);
    // Already in debug mode, so no entry check
    r.dbg            = 3'd4;
    r.csr_dcsr_rdata = dcsr_with_cause(3'd1);
    push_rec(r, 5'b0);
    push_rec(blank_record(), 5'b0);
    check_regs("debug cause");
  endtask

  task automatic test_exception_cause();
    rvfi_rec_t   r;
    logic [5:0]  cause;
    logic [31:0] target;
    for (int n = 0; n < 8; n++) begin
      cause  = 6'(xorshift32() % 63) + 6'd1;
      target = {26'b0, cause};
      r = blank_record();
      r.trap.exception       = 1'b1;
      r.trap.exception_cause = cause;
      r.csr_mcause_wmask     = xorshift32() | target;
      r.csr_mcause_wdata     = target | (xorshift32() & ~r.csr_mcause_wmask);
      push_rec(r, 5'b0);
    end
    r = blank_record();
    r.trap.exception       = 1'b1;
    r.trap.exception_cause = 6'd5;
    r.csr_mcause_wdata     = 32'd6;
    r.csr_mcause_wmask     = 32'hFFFF_FFFF;
    push_rec(r, F_EXC);
    // Same mismatch inside debug mode is not checked
    r.dbg_mode = 1'b1;
    push_rec(r, 5'b0);
    push_rec(blank_record(), 5'b0);
    check_regs("exception cause");
  endtask

  task automatic test_interrupt_cause();
    rvfi_rec_t   r;
    logic [31:0] rnd;
    logic [10:0] cause;
    logic        legal;
    logic [31:0] data;
    int          n_illegal;
    wb_write(REG_CLEAR, 32'hFFFF_FFFF);
    clear_model();
    n_illegal = 0;
    for (int n = 0; n < 20; n++) begin
      rnd = xorshift32();
      if (rnd[0]) begin
        case (rnd[2:1])
          2'd0:    cause = 11'd3 + 11'(4 * (rnd[4:3] % 3));
          2'd1:    cause = 11'd16 + 11'(rnd[8:5]);
          2'd2:    cause = 11'd1024 + 11'(rnd[10:9]);
          default: cause = 11'd7;
        endcase
      end else begin
        cause = rnd[21:11];
        if (cause == 11'd0) begin
          cause = 11'd1;
        end
      end
      legal = clint_legal(cause);
      if (!legal) begin
        n_illegal++;
      end
      r = blank_record();
      r.intr.interrupt = 1'b1;
      r.intr.cause     = cause;
      push_rec(r, legal ? 5'b0 : F_IRQ);
    end
    wb_read(REG_CNT_BASE + 4'd3, data);
    check_equal(data, 32'(n_illegal), "illegal interrupt count");
    // Zero causes, interrupt zero is also outside the legal set
    r = blank_record();
    r.intr.interrupt = 1'b1;
    push_rec(r, F_IRQ | F_MISS);
    r = blank_record();
    r.intr.exception = 1'b1;
    push_rec(r, F_MISS);
    r = blank_record();
    r.trap.exception   = 1'b1;
    r.csr_mcause_wmask = 32'hFFFF_FFFF;
    push_rec(r, F_MISS);
    check_regs("interrupt cause");
  endtask

  task automatic test_register_port();
    rvfi_rec_t   r;
    logic [31:0] data;
    wb_write(REG_CLEAR, 32'hFFFF_FFFF);
    clear_model();
    for (int n = 0; n < 3; n++) begin
      push_rec(blank_record(), 5'b0);
    end
    // Two classes at once, the lower index is captured
    r = blank_record();
    r.trap.exception       = 1'b1;
    r.trap.exception_cause = 6'd9;
    r.csr_mcause_wdata     = 32'd8;
    r.csr_mcause_wmask     = 32'hFFFF_FFFF;
    r.intr.interrupt       = 1'b1;
    r.intr.cause           = 11'd100;
    push_rec(r, F_EXC | F_IRQ);
    r = blank_record();
    r.dbg              = 3'd2;
    r.csr_dcsr_rdata   = dcsr_with_cause(3'd5);
    r.trap.debug       = 1'b1;
    r.trap.debug_cause = 3'd2;
    r.dbg_mode         = 1'b1;
    push_rec(r, F_DBG);
    push_rec(blank_record(), 5'b0);
    wb_read(REG_RETIRED, data);
    check_equal(data, 32'd6, "retired count");
    wb_read(REG_FIRST, data);
    check_equal(data, 32'h0000_0382, "first failure word");
    check_regs("register port");
    wb_write(REG_STATUS, 32'hFFFF_FFFF);
    check_regs("ignored write");
    wb_read(4'hF, data);
    check_equal(data, 32'h0, "unmapped read");
    wb_write(REG_CLEAR, 32'hFFFF_FFFF);
    clear_model();
    check_regs("after final clear");
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    rvfi       = '0;
    wb_req     = '0;
    errors     = 0;
    rand_state = 32'd42;
    clear_model();
    do_reset();
    test_reset_rule();
    test_debug_cause();
    test_exception_cause();
    test_interrupt_cause();
    test_register_port();
    $display("Simulation finished with %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
